// File: vlog.f
+incdir+include
design/mips_pkg.sv
design/pipe_reg.sv
design/decoder.sv
design/gpr.sv
design/alu.sv
design/forward_unit.sv
design/control_unit.sv
design/mips_pipeline.sv
dv/mips_pipeline_props.sv
dv/tb_mips_pipeline.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_mips_pipeline
FILELIST  := vlog.f
BUILD_DIR := obj_dir
RUN_FLAGS := +verilator+error+limit+10

SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/tb_mips_pipeline.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module tb_mips_pipeline import mips_pkg::*; ();

    localparam int    IMEM_WORDS      = 64;
    localparam int    DMEM_WORDS      = 64;
    localparam int    MAX_STORES      = 16;
    localparam word_t LAST_STORE_ADDR = 32'h0000_00FC;
    localparam word_t IDLE_RDATA      = 32'hBAD0_BAD0;
    // Program, load-use stalls and branch flush take about 50 cycles
    localparam int    MAX_CYCLES      = 4 * 50;

    logic  clk;
    logic  rst;
    word_t imem_addr;
    word_t imem_data;
    logic  dmem_read;
    logic  dmem_write;
    word_t dmem_addr;
    word_t dmem_wdata;
    word_t dmem_rdata;
    word_t mem_pc_out;

    word_t imem [0:IMEM_WORDS-1];
    word_t dmem [0:DMEM_WORDS-1];
    word_t exp_addr [0:MAX_STORES-1];
    word_t exp_data [0:MAX_STORES-1];
    string exp_name [0:MAX_STORES-1];
    int    exp_count;
    int    prog_len;
    int    seen = 0;
    int    cycles;

    mips_pipeline DUT (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .imem_addr  ( imem_addr  ),
        .imem_data  ( imem_data  ),
        .dmem_read  ( dmem_read  ),
        .dmem_write ( dmem_write ),
        .dmem_addr  ( dmem_addr  ),
        .dmem_wdata ( dmem_wdata ),
        .dmem_rdata ( dmem_rdata ),
        .mem_pc_out ( mem_pc_out )
    );

    //////////////////////////////////////////////////////////////////////
    // Encoders and memory contents
    //////////////////////////////////////////////////////////////////////

    function automatic word_t r_instr(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd, input logic [5:0] fn);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t i_instr(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Power-on data word hashed from the byte address
    function automatic word_t fill_word(input word_t addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_1234;
    endfunction

    task automatic put_instr(input word_t instr);
        imem[prog_len] = instr;
        prog_len = prog_len + 1;
    endtask

    task automatic expect_store(input word_t addr, input word_t data, input string name);
        exp_addr[exp_count] = addr;
        exp_data[exp_count] = data;
        exp_name[exp_count] = name;
        exp_count = exp_count + 1;
    endtask

    task automatic build_program();
        prog_len  = 0;
        exp_count = 0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        // Dependent ALU chain with every result forwarded
        put_instr(i_instr(`OP_ADDIU, 5'd0, 5'd1, 16'h003C));
        put_instr(i_instr(`OP_ADDIU, 5'd1, 5'd2, 16'h000F));
        put_instr(r_instr(5'd1, 5'd2, 5'd3, `FN_ADDU));
        put_instr(r_instr(5'd3, 5'd2, 5'd4, `FN_SUBU));
        put_instr(r_instr(5'd3, 5'd2, 5'd5, `FN_AND));
        put_instr(r_instr(5'd5, 5'd4, 5'd6, `FN_OR));
        put_instr(r_instr(5'd5, 5'd4, 5'd7, `FN_SLT));
        put_instr(i_instr(`OP_ORI, 5'd6, 5'd8, 16'h8000));
        put_instr(i_instr(`OP_LUI, 5'd0, 5'd9, 16'hBEEF));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd9, 16'h0000));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd8, 16'h0004));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd3, 16'h0008));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd4, 16'h000C));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd5, 16'h0010));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd6, 16'h0014));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd7, 16'h0018));
        put_instr(i_instr(`OP_ADDIU, 5'd0, 5'd10, 16'hFFFC));
        put_instr(r_instr(5'd10, 5'd0, 5'd11, `FN_SLT));
        put_instr(r_instr(5'd0, 5'd1, 5'd12, `FN_SUBU));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd12, 16'h001C));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd11, 16'h0020));
        // Load-use through rs and then as store data
        put_instr(i_instr(`OP_ADDIU, 5'd0, 5'd13, 16'h0080));
        put_instr(i_instr(`OP_LW, 5'd13, 5'd14, 16'h0040));
        put_instr(r_instr(5'd14, 5'd1, 5'd15, `FN_ADDU));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd15, 16'h0024));
        put_instr(i_instr(`OP_LW, 5'd13, 5'd16, 16'h0044));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd16, 16'h0028));
        // Taken beq skips three marker stores and lands on index 32
        put_instr(i_instr(`OP_ORI, 5'd0, 5'd17, 16'hDEAD));
        put_instr(i_instr(`OP_BEQ, 5'd1, 5'd1, 16'd3));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd17, 16'h0030));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd17, 16'h0034));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd17, 16'h0038));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd1, 16'h002C));
        // Not-taken bne before the closing store
        put_instr(i_instr(`OP_BNE, 5'd2, 5'd2, 16'd4));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd2, 16'h003C));
        put_instr(r_instr(5'd3, 5'd4, 5'd20, `FN_ADDU));
        put_instr(i_instr(`OP_SW, 5'd0, 5'd20, 16'h00FC));

        // $1 = 0x3C, $2 = 0x4B, $3 = 0x87, $4 = 0x3C
        expect_store(32'h00, 32'hBEEF_0000, "lui");
        expect_store(32'h04, 32'h0000_003F | 32'h0000_8000, "ori");
        expect_store(32'h08, 32'h3C + 32'h4B, "addu");
        expect_store(32'h0C, 32'h87 - 32'h4B, "subu");
        expect_store(32'h10, 32'h87 & 32'h4B, "and");
        expect_store(32'h14, 32'h03 | 32'h3C, "or");
        expect_store(32'h18, 32'h1, "slt positive");
        expect_store(32'h1C, 32'h0 - 32'h3C, "subu negative");
        expect_store(32'h20, 32'h1, "slt signed");
        expect_store(32'h24, fill_word(32'hC0) + 32'h3C, "load-use addu");
        expect_store(32'h28, fill_word(32'hC4), "load-use store data");
        expect_store(32'h2C, 32'h3C, "beq target");
        expect_store(32'h3C, 32'h4B, "bne not taken");
        expect_store(32'hFC, 32'h87 + 32'h3C, "final sum");
    endtask

    task automatic report_failure();
        $display("Done: errors found");
        $fatal(1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Clock, reset and memory models
    //////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        build_program();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

    assign imem_data  = imem[imem_addr[7:2]];

    // Only a strobed read returns memory contents
    assign dmem_rdata = dmem_read ? dmem[dmem_addr[7:2]] : IDLE_RDATA;

    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fill_word(32'(i) << 2);
            end
        end else if (dmem_write) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
            assert (cycles < MAX_CYCLES) else begin
                $display("Timeout after %0d cycles without the final store", cycles);
                report_failure();
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Store checks at the falling edge
    //////////////////////////////////////////////////////////////////////

    task automatic check_store();
        logic [5:0] op;
        op = imem[mem_pc_out[7:2]][31:26];
        assert (dmem_wdata != 32'h0000_DEAD) else begin
            $display("A wrong-path store after the taken branch reached data memory");
            report_failure();
        end
        assert (op == `OP_SW) else begin
            $display("Data memory write from PC %h, which does not hold a sw", mem_pc_out);
            report_failure();
        end
        assert (seen < exp_count) else begin
            $display("More stores reached data memory than the program issues");
            report_failure();
        end
        assert (dmem_addr == exp_addr[seen]) else begin
            $display("FAIL %s address: expected %h, actual %h",
                     exp_name[seen], exp_addr[seen], dmem_addr);
            report_failure();
        end
        assert (dmem_wdata == exp_data[seen]) else begin
            $display("FAIL %s data: expected %h, actual %h",
                     exp_name[seen], exp_data[seen], dmem_wdata);
            report_failure();
        end
        seen = seen + 1;
        if (dmem_addr == LAST_STORE_ADDR) begin
            if (seen == exp_count) begin
                $display("Done: no errors");
                $finish;
            end else begin
                $display("Final store came after only %0d of %0d stores", seen, exp_count);
                report_failure();
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            assert (!DUT.props.failed) else begin
                $display("A bound assertion on the DUT memory ports failed");
                report_failure();
            end
            if (dmem_read) begin
                assert (imem[mem_pc_out[7:2]][31:26] == `OP_LW) else begin
                    $display("Data memory read from PC %h, which does not hold a lw",
                             mem_pc_out);
                    report_failure();
                end
            end
            if (dmem_write) begin
                check_store();
            end
        end
    end

endmodule

// File: dv/mips_pipeline_props.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_pipeline_props import mips_pkg::*; (
    input logic   clk,
    input logic   rst,
    input word_t  imem_addr,
    input logic   dmem_read,
    input logic   dmem_write,
    input word_t  mem_pc_out,
    input exmem_t exmem_q
);

    logic  mem_valid;
    logic  have_prev;
    word_t next_pc_exp;
    logic  err_reset = 1'b0;
    logic  err_fetch = 1'b0;
    logic  err_rw    = 1'b0;
    logic  err_align = 1'b0;
    logic  err_order = 1'b0;
    logic  failed;

    // A bubble in MEM is an all-zero EX/MEM register
    assign mem_valid = (exmem_q != '0);

    // PC the next real instruction in MEM has to carry
    // A taken branch flushes, so the sequence starts over after it
    always_ff @(posedge clk) begin
        if (rst || exmem_q.take_branch) begin
            have_prev   <= 1'b0;
            next_pc_exp <= '0;
        end else if (mem_valid) begin
            have_prev   <= 1'b1;
            next_pc_exp <= mem_pc_out + 32'd4;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Memory port properties
    //////////////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) rst |=> (!dmem_read && !dmem_write))
        else begin
            err_reset = 1'b1;
            $error("Data memory strobe active during or right after reset");
        end

    a_first_fetch: assert property (@(posedge clk) $fell(rst) |-> (imem_addr == `RESET_PC))
        else begin
            err_fetch = 1'b1;
            $error("First fetch after reset is not at the reset PC");
        end

    a_rw_exclusive: assert property (@(posedge clk) disable iff (rst)
                                     !(dmem_read && dmem_write))
        else begin
            err_rw = 1'b1;
            $error("Data memory read and write strobes high together");
        end

    a_fetch_aligned: assert property (@(posedge clk) disable iff (rst)
                                      imem_addr[1:0] == 2'b00)
        else begin
            err_align = 1'b1;
            $error("Instruction fetch address is not word aligned");
        end

    // Bubbles are skipped between real instructions
    a_mem_order: assert property (@(posedge clk) disable iff (rst)
                                  (mem_valid && have_prev) |-> (mem_pc_out == next_pc_exp))
        else begin
            err_order = 1'b1;
            $error("Instruction reached MEM out of program order");
        end

    assign failed = err_reset | err_fetch | err_rw | err_align | err_order;

endmodule

bind mips_pipeline mips_pipeline_props props (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .imem_addr  ( imem_addr  ),
    .dmem_read  ( dmem_read  ),
    .dmem_write ( dmem_write ),
    .mem_pc_out ( mem_pc_out ),
    .exmem_q    ( exmem_q    )
);

// File: design/mips_pipeline.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module mips_pipeline import mips_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output word_t imem_addr,
    input  word_t imem_data,
    output logic  dmem_read,
    output logic  dmem_write,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    input  word_t dmem_rdata,
    output word_t mem_pc_out
);

    word_t     pc;
    word_t     pc_next;
    word_t     if_pc_4;
    ifid_t     if_d;
    ifid_t     ifid_q;
    idex_t     id_d;
    idex_t     idex_q;
    exmem_t    ex_d;
    exmem_t    exmem_q;
    memwb_t    mem_d;
    memwb_t    memwb_q;
    ctrl_t     id_ctrl;
    reg_addr_t id_rs_addr;
    reg_addr_t id_rt_addr;
    reg_addr_t id_rd_addr;
    word_t     id_imm;
    word_t     id_rs_data;
    word_t     id_rt_data;
    fwd_sel_t  sel_a;
    fwd_sel_t  sel_b;
    word_t     op_a;
    word_t     op_b_fwd;
    word_t     op_b;
    word_t     alu_res;
    logic      alu_zero;
    word_t     wb_data;
    logic      pc_stall;
    logic      ifid_stall;
    logic      ifid_flush;
    logic      idex_flush;
    logic      exmem_flush;
    logic      pc_sel;

    function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val,
                                      input word_t mem_val, input word_t wb_val);
        case (sel)
            FWD_EXMEM: return mem_val;
            FWD_MEMWB: return wb_val;
            default:   return reg_val;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // IF
    //////////////////////////////////////////////////////////////////////

    assign if_pc_4 = pc + 32'd4;
    assign pc_next = pc_sel ? exmem_q.target : if_pc_4;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
        end else if (!pc_stall) begin
            pc <= pc_next;
        end
    end

    assign imem_addr = pc;
    assign if_d      = '{pc: pc, pc_4: if_pc_4, instr: imem_data};

    pipe_reg #(.payload_t(ifid_t)) ifid_reg (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .stall ( ifid_stall ),
        .flush ( ifid_flush ),
        .d     ( if_d       ),
        .q     ( ifid_q     )
    );

    //////////////////////////////////////////////////////////////////////
    // ID
    //////////////////////////////////////////////////////////////////////

    decoder id_decoder (
        .instr   ( ifid_q.instr ),
        .ctrl    ( id_ctrl      ),
        .rs_addr ( id_rs_addr   ),
        .rt_addr ( id_rt_addr   ),
        .rd_addr ( id_rd_addr   ),
        .imm     ( id_imm       )
    );

    gpr id_gpr (
        .clk     ( clk             ),
        .rst     ( rst             ),
        .we      ( memwb_q.reg_w   ),
        .waddr   ( memwb_q.rd_addr ),
        .wdata   ( wb_data         ),
        .raddr_a ( id_rs_addr      ),
        .raddr_b ( id_rt_addr      ),
        .rdata_a ( id_rs_data      ),
        .rdata_b ( id_rt_data      )
    );

    assign id_d = '{ctrl: id_ctrl, pc: ifid_q.pc, pc_4: ifid_q.pc_4,
                    rs_data: id_rs_data, rt_data: id_rt_data, imm: id_imm,
                    rs_addr: id_rs_addr, rt_addr: id_rt_addr, rd_addr: id_rd_addr};

    pipe_reg #(.payload_t(idex_t)) idex_reg (
        .clk   ( clk        ),
        .rst   ( rst        ),
        .stall ( 1'b0       ),
        .flush ( idex_flush ),
        .d     ( id_d       ),
        .q     ( idex_q     )
    );

    //////////////////////////////////////////////////////////////////////
    // EX
    //////////////////////////////////////////////////////////////////////

    forward_unit ex_fwd (
        .ex_rs_addr  ( idex_q.rs_addr  ),
        .ex_rt_addr  ( idex_q.rt_addr  ),
        .mem_reg_w   ( exmem_q.reg_w   ),
        .mem_rd_addr ( exmem_q.rd_addr ),
        .wb_reg_w    ( memwb_q.reg_w   ),
        .wb_rd_addr  ( memwb_q.rd_addr ),
        .sel_a       ( sel_a           ),
        .sel_b       ( sel_b           )
    );

    // Forwarding first, immediate select after, so sw keeps its rt value
    assign op_a     = fwd_mux(sel_a, idex_q.rs_data, exmem_q.alu_res, wb_data);
    assign op_b_fwd = fwd_mux(sel_b, idex_q.rt_data, exmem_q.alu_res, wb_data);
    assign op_b     = idex_q.ctrl.b_imm ? idex_q.imm : op_b_fwd;

    alu ex_alu (
        .a      ( op_a               ),
        .b      ( op_b               ),
        .op     ( idex_q.ctrl.alu_op ),
        .result ( alu_res            ),
        .zero   ( alu_zero           )
    );

    // beq wants zero, bne wants nonzero
    assign ex_d = '{reg_w: idex_q.ctrl.reg_w, mem_r: idex_q.ctrl.mem_r,
                    mem_w: idex_q.ctrl.mem_w,
                    take_branch: idex_q.ctrl.branch && (alu_zero ^ idex_q.ctrl.branch_ne),
                    target: idex_q.pc_4 + (idex_q.imm << 2), alu_res: alu_res,
                    store_data: op_b_fwd, rd_addr: idex_q.rd_addr, pc: idex_q.pc};

    pipe_reg #(.payload_t(exmem_t)) exmem_reg (
        .clk   ( clk         ),
        .rst   ( rst         ),
        .stall ( 1'b0        ),
        .flush ( exmem_flush ),
        .d     ( ex_d        ),
        .q     ( exmem_q     )
    );

    //////////////////////////////////////////////////////////////////////
    // MEM and WB
    //////////////////////////////////////////////////////////////////////

    assign dmem_read  = exmem_q.mem_r;
    assign dmem_write = exmem_q.mem_w;
    assign dmem_addr  = exmem_q.alu_res;
    assign dmem_wdata = exmem_q.store_data;
    assign mem_pc_out = exmem_q.pc;

    assign mem_d = '{reg_w: exmem_q.reg_w, mem_r: exmem_q.mem_r, alu_res: exmem_q.alu_res,
                     mem_data: dmem_rdata, rd_addr: exmem_q.rd_addr};

    pipe_reg #(.payload_t(memwb_t)) memwb_reg (
        .clk   ( clk     ),
        .rst   ( rst     ),
        .stall ( 1'b0    ),
        .flush ( 1'b0    ),
        .d     ( mem_d   ),
        .q     ( memwb_q )
    );

    assign wb_data = memwb_q.mem_r ? memwb_q.mem_data : memwb_q.alu_res;

    control_unit ctrl_unit (
        .ex_mem_r    ( idex_q.ctrl.mem_r   ),
        .ex_rd_addr  ( idex_q.rd_addr      ),
        .id_rs_addr  ( id_rs_addr          ),
        .id_rt_addr  ( id_rt_addr          ),
        .take_branch ( exmem_q.take_branch ),
        .pc_stall    ( pc_stall            ),
        .ifid_stall  ( ifid_stall          ),
        .ifid_flush  ( ifid_flush          ),
        .idex_flush  ( idex_flush          ),
        .exmem_flush ( exmem_flush         ),
        .pc_sel      ( pc_sel              )
    );

endmodule

// File: design/control_unit.sv
`timescale 1ns/1ps

module control_unit import mips_pkg::*; (
    input  logic      ex_mem_r,
    input  reg_addr_t ex_rd_addr,
    input  reg_addr_t id_rs_addr,
    input  reg_addr_t id_rt_addr,
    input  logic      take_branch,
    output logic      pc_stall,
    output logic      ifid_stall,
    output logic      ifid_flush,
    output logic      idex_flush,
    output logic      exmem_flush,
    output logic      pc_sel
);

    logic load_use;

    //////////////////////////////////////////////////////////////////////
    // Load-use hazard
    //////////////////////////////////////////////////////////////////////

    // Load in EX whose target is read by the instruction in ID
    assign load_use = ex_mem_r && (ex_rd_addr != '0) &&
                      ((ex_rd_addr == id_rs_addr) || (ex_rd_addr == id_rt_addr));

    //////////////////////////////////////////////////////////////////////
    // Stall and flush steering
    //////////////////////////////////////////////////////////////////////

    // A taken branch kills whatever would have stalled
    assign pc_stall   = load_use && !take_branch;
    assign ifid_stall = load_use && !take_branch;

    // Bubble into EX while the user waits one cycle in ID
    assign idex_flush = load_use || take_branch;

    // Three younger stages hold the wrong path
    assign ifid_flush  = take_branch;
    assign exmem_flush = take_branch;

    // 1 picks the branch target from EX/MEM
    assign pc_sel = take_branch;

endmodule

// File: design/forward_unit.sv
`timescale 1ns/1ps

module forward_unit import mips_pkg::*; (
    input  reg_addr_t ex_rs_addr,
    input  reg_addr_t ex_rt_addr,
    input  logic      mem_reg_w,
    input  reg_addr_t mem_rd_addr,
    input  logic      wb_reg_w,
    input  reg_addr_t wb_rd_addr,
    output fwd_sel_t  sel_a,
    output fwd_sel_t  sel_b
);

    logic mem_valid;
    logic wb_valid;

    // Writers to $0 never forward
    assign mem_valid = mem_reg_w && (mem_rd_addr != '0);
    assign wb_valid  = wb_reg_w && (wb_rd_addr != '0);

    // Younger result in EX/MEM takes priority
    always_comb begin
        if (mem_valid && mem_rd_addr == ex_rs_addr) begin
            sel_a = FWD_EXMEM;
        end else if (wb_valid && wb_rd_addr == ex_rs_addr) begin
            sel_a = FWD_MEMWB;
        end else begin
            sel_a = FWD_IDEX;
        end

        if (mem_valid && mem_rd_addr == ex_rt_addr) begin
            sel_b = FWD_EXMEM;
        end else if (wb_valid && wb_rd_addr == ex_rt_addr) begin
            sel_b = FWD_MEMWB;
        end else begin
            sel_b = FWD_IDEX;
        end
    end

endmodule

// File: design/alu.sv
`timescale 1ns/1ps

module alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t op,
    output word_t   result,
    output logic    zero
);

    logic less;

    // Signed compare for slt
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_SLT: begin
                result = word_t'(less);
            end
            ALU_LUI: begin
                result = b << 16;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Branches compare with a subtract, equal operands give zero
    assign zero = (result == '0);

endmodule

// File: design/gpr.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module gpr (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       we,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`DATA_WIDTH-1:0]     wdata,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr_a,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr_b,
    output logic [`DATA_WIDTH-1:0]     rdata_a,
    output logic [`DATA_WIDTH-1:0]     rdata_b
);

    logic [`DATA_WIDTH-1:0] regs [0:(1<<`REG_ADDR_WIDTH)-1];
    logic                   wr_ok;

    // $0 never gets written, so it stays at its reset value
    assign wr_ok = we && (waddr != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[waddr] <= wdata;
        end
    end

    // WB and ID in the same cycle see the new value
    assign rdata_a = (wr_ok && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (wr_ok && waddr == raddr_b) ? wdata : regs[raddr_b];

endmodule

// File: design/decoder.sv
`timescale 1ns/1ps

`include "mips_defines.svh"

module decoder import mips_pkg::*; (
    input  word_t     instr,
    output ctrl_t     ctrl,
    output reg_addr_t rs_addr,
    output reg_addr_t rt_addr,
    output reg_addr_t rd_addr,
    output word_t     imm
);

    logic [5:0] opcode;
    logic [5:0] funct;
    word_t      sign_imm;
    word_t      zero_imm;

    assign opcode   = instr[31:26];
    assign funct    = instr[5:0];
    assign rs_addr  = instr[25:21];
    assign rt_addr  = instr[20:16];
    assign sign_imm = {{16{instr[15]}}, instr[15:0]};
    assign zero_imm = {16'h0000, instr[15:0]};

    always_comb begin
        ctrl    = '0;
        rd_addr = '0;
        imm     = sign_imm;
        case (opcode)
            `OP_RTYPE: begin
                rd_addr    = instr[15:11];
                ctrl.reg_w = 1'b1;
                case (funct)
                    `FN_ADDU: ctrl.alu_op = ALU_ADD;
                    `FN_SUBU: ctrl.alu_op = ALU_SUB;
                    `FN_AND:  ctrl.alu_op = ALU_AND;
                    `FN_OR:   ctrl.alu_op = ALU_OR;
                    `FN_SLT:  ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl    = '0;
                        rd_addr = '0;
                    end
                endcase
            end
            `OP_ADDIU: begin
                rd_addr    = rt_addr;
                ctrl.reg_w = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            `OP_ORI: begin
                rd_addr     = rt_addr;
                imm         = zero_imm;
                ctrl.reg_w  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = ALU_OR;
            end
            `OP_LUI: begin
                // ALU does the shift by 16
                rd_addr     = rt_addr;
                imm         = zero_imm;
                ctrl.reg_w  = 1'b1;
                ctrl.b_imm  = 1'b1;
                ctrl.alu_op = ALU_LUI;
            end
            `OP_LW: begin
                rd_addr    = rt_addr;
                ctrl.reg_w = 1'b1;
                ctrl.mem_r = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            `OP_SW: begin
                ctrl.mem_w = 1'b1;
                ctrl.b_imm = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;
            end
            `OP_BNE: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// File: design/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg import mips_pkg::*; #(
    parameter type payload_t = ifid_t
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     stall,
    input  logic     flush,
    input  payload_t d,
    output payload_t q
);

    // Flush beats stall, so a taken branch can kill a held stage
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            q <= '0;
        end else if (!stall) begin
            q <= d;
        end
    end

endmodule

// File: design/mips_pkg.sv
`include "mips_defines.svh"

package mips_pkg;

    typedef logic [`DATA_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;

    // Zero encoding doubles as the bubble op
    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4,
        ALU_LUI = 3'd5
    } alu_op_t;

    // All zero is a bubble
    typedef struct packed {
        logic    reg_w;
        logic    mem_r;
        logic    mem_w;
        logic    branch;
        logic    branch_ne;
        logic    b_imm;
        alu_op_t alu_op;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc_4;
        word_t instr;
    } ifid_t;

    typedef struct packed {
        ctrl_t     ctrl;
        word_t     pc;
        word_t     pc_4;
        word_t     rs_data;
        word_t     rt_data;
        word_t     imm;
        reg_addr_t rs_addr;
        reg_addr_t rt_addr;
        reg_addr_t rd_addr;
    } idex_t;

    typedef struct packed {
        logic      reg_w;
        logic      mem_r;
        logic      mem_w;
        logic      take_branch;
        word_t     target;
        word_t     alu_res;
        word_t     store_data;
        reg_addr_t rd_addr;
        word_t     pc;
    } exmem_t;

    typedef struct packed {
        logic      reg_w;
        logic      mem_r;
        word_t     alu_res;
        word_t     mem_data;
        reg_addr_t rd_addr;
    } memwb_t;

    // Operand source in EX
    typedef enum logic [1:0] {
        FWD_IDEX  = 2'd0,
        FWD_EXMEM = 2'd1,
        FWD_MEMWB = 2'd2
    } fwd_sel_t;

endpackage

// File: include/mips_defines.svh
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// Datapath widths
`define DATA_WIDTH      32
`define REG_ADDR_WIDTH  5

// First fetch address out of reset
`define RESET_PC        32'h0000_0000

// Primary opcodes, instr[31:26]
`define OP_RTYPE        6'h00
`define OP_BEQ          6'h04
`define OP_BNE          6'h05
`define OP_ADDIU        6'h09
`define OP_ORI          6'h0d
`define OP_LUI          6'h0f
`define OP_LW           6'h23
`define OP_SW           6'h2b

// R-type funct field, instr[5:0]
`define FN_ADDU         6'h21
`define FN_SUBU         6'h23
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_SLT          6'h2a

`endif
